// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Datapath width shared by data words and addresses.
	localparam int word_w = 16; // One machine word.

	typedef logic [word_w-1:0] word_t; // Data or address value.

	// Top of the address space is taken by the I/O ports.
	localparam word_t io_addr = 16'hFFFF; // Maps to io_in and io_out.

	// Instruction field widths.
	localparam int ctrl_w = 7; // Control field, bits 15..9.

	typedef logic [ctrl_w-1:0] ctrl_t; // Control field value.
	typedef logic [2:0] reg_idx_t; // Register file index.

	// Branch conditions tested against the ALU flags.
	typedef enum logic [1:0] {
		br_eq = 2'd0, // Zero set.
		br_ne = 2'd1, // Zero clear.
		br_lt = 2'd2, // Negative set.
		br_ge = 2'd3 // Negative clear.
	} branch_type_e;

	// Memory address sources.
	// Code 3 is unused and resolves to the PC.
	typedef enum logic [1:0] {
		addr_pc = 2'd0, // Instruction fetch.
		addr_alu = 2'd1, // Computed address.
		addr_a = 2'd2 // Base held in A.
	} addr_sel_e;

endpackage

`default_nettype wire

// File: hdl/fetch_memory.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_memory #(
	parameter int mem_words = 4096 // Words in the unified memory.
) (
	input  wire                        clk, // System clock.
	input  wire                        rst, // Sync reset, active high.
	// PC control.
	input  wire                        pc_write, // PC load strobe.
	input  wire                        pc_is_branch, // Load is conditional.
	input  wire cpu_pkg::word_t        new_pc, // Next PC value.
	input  wire cpu_pkg::branch_type_e branch_type, // Branch condition.
	input  wire                        zero, // ALU zero flag.
	input  wire                        negative, // ALU negative flag.
	// Memory control and data.
	input  wire cpu_pkg::addr_sel_e    addr_sel, // Address source.
	input  wire cpu_pkg::word_t        alu_out, // ALU result.
	input  wire cpu_pkg::word_t        a_reg, // A register.
	input  wire                        mem_write, // Store strobe.
	input  wire cpu_pkg::word_t        mem_wdata, // Store data.
	input  wire cpu_pkg::word_t        io_in, // Input port.
	input  wire                        ir_write, // Instruction capture.
	// Outputs.
	output cpu_pkg::word_t             pc, // Program counter.
	output cpu_pkg::word_t             mdr, // Memory data register.
	output cpu_pkg::word_t             io_out, // Output port.
	output cpu_pkg::ctrl_t             ir_ctrl, // Control field.
	output cpu_pkg::reg_idx_t          ir_rega, // Source A index.
	output cpu_pkg::reg_idx_t          ir_regb, // Source B index.
	output cpu_pkg::reg_idx_t          ir_regd, // Destination index.
	output cpu_pkg::word_t             ir_imm // Sign-extended immediate.
);

	import cpu_pkg::*;

	word_t mem_q; // Read word into the IR.

	program_counter pc_i (
		.clk          (clk),
		.rst          (rst),
		.pc_write     (pc_write),
		.pc_is_branch (pc_is_branch),
		.new_pc       (new_pc),
		.branch_type  (branch_type),
		.zero         (zero),
		.negative     (negative),
		.pc           (pc)
	);

	unified_memory #(
		.mem_words (mem_words)
	) mem_i (
		.clk       (clk),
		.rst       (rst),
		.addr_sel  (addr_sel),
		.pc        (pc), // Fetch address.
		.alu_out   (alu_out),
		.a_reg     (a_reg),
		.mem_write (mem_write),
		.wdata     (mem_wdata),
		.io_in     (io_in),
		.q         (mem_q),
		.mdr       (mdr),
		.io_out    (io_out)
	);

	instruction_register ir_i (
		.clk      (clk),
		.rst      (rst),
		.ir_write (ir_write),
		.instr    (mem_q), // Word read on the previous edge.
		.ctrl     (ir_ctrl),
		.rega     (ir_rega),
		.regb     (ir_regb),
		.regd     (ir_regd),
		.imm      (ir_imm)
	);

endmodule

`default_nettype wire

// File: hdl/instruction_register.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_register (
	input  wire                    clk, // System clock.
	input  wire                    rst, // Sync reset, active high.
	input  wire                    ir_write, // Capture strobe.
	input  wire cpu_pkg::word_t    instr, // Word from memory.
	output cpu_pkg::ctrl_t         ctrl, // Control field.
	output cpu_pkg::reg_idx_t      rega, // First source register.
	output cpu_pkg::reg_idx_t      regb, // Second source register.
	output cpu_pkg::reg_idx_t      regd, // Destination register.
	output cpu_pkg::word_t         imm // Sign-extended immediate.
);

	import cpu_pkg::*;

	word_t ir_q; // Held instruction word.

	always_ff @(posedge clk) begin
		if (rst) begin
			ir_q <= '0; // All fields read zero.
		end else if (ir_write) begin
			ir_q <= instr; // Latch the fetched word.
		end
	end

	// Field split of the held word.
	assign ctrl = ir_q[15:9]; // Opcode and function bits.
	assign regd = ir_q[8:6]; // Destination.
	assign rega = ir_q[5:3]; // Source A.
	assign regb = ir_q[2:0]; // Source B.

	// The immediate overlaps rega and regb.
	assign imm = {{(word_w-6){ir_q[5]}}, ir_q[5:0]}; // Six bits, sign extended.

endmodule

`default_nettype wire

// File: hdl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
	input  wire                        clk, // System clock.
	input  wire                        rst, // Sync reset, active high.
	input  wire                        pc_write, // Load strobe from control.
	input  wire                        pc_is_branch, // Load is a conditional branch.
	input  wire cpu_pkg::word_t        new_pc, // Target address.
	input  wire cpu_pkg::branch_type_e branch_type, // Condition to test.
	input  wire                        zero, // ALU result was zero.
	input  wire                        negative, // ALU result was negative.
	output cpu_pkg::word_t             pc // Current program counter.
);

	import cpu_pkg::*;

	logic cond_met; // Branch condition holds.
	logic pc_load; // PC takes new_pc this edge.

	// Resolve the branch condition from the flags.
	always_comb begin
		case (branch_type)
			br_eq: begin
				cond_met = zero; // Equal.
			end
			br_ne: begin
				cond_met = ~zero; // Not equal.
			end
			br_lt: begin
				cond_met = negative; // Less than.
			end
			br_ge: begin
				cond_met = ~negative; // Greater or equal.
			end
			default: begin
				cond_met = 1'b0;
			end
		endcase
	end

	// Plain writes always load, branches only when taken.
	assign pc_load = pc_write & (~pc_is_branch | cond_met);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0; // Start fetching at address 0.
		end else if (pc_load) begin
			pc <= new_pc; // Jump or sequential step.
		end
	end

endmodule

`default_nettype wire

// File: hdl/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory #(
	parameter int mem_words = 4096 // Array depth, power of two.
) (
	input  wire                     clk, // System clock.
	input  wire                     rst, // Sync reset, active high.
	input  wire cpu_pkg::addr_sel_e addr_sel, // Address source select.
	input  wire cpu_pkg::word_t     pc, // Program counter.
	input  wire cpu_pkg::word_t     alu_out, // ALU result.
	input  wire cpu_pkg::word_t     a_reg, // A register.
	input  wire                     mem_write, // Write strobe.
	input  wire cpu_pkg::word_t     wdata, // Write data.
	input  wire cpu_pkg::word_t     io_in, // Input port.
	output cpu_pkg::word_t          q, // Read word, one edge after the address.
	output cpu_pkg::word_t          mdr, // Memory data register.
	output cpu_pkg::word_t          io_out // Output port register.
);

	import cpu_pkg::*;

	localparam int idx_w = $clog2(mem_words); // Array index width.

	word_t mem [mem_words]; // Unified instruction and data store.

	word_t addr; // Selected address.
	logic [idx_w-1:0] idx; // Low address bits into the array.
	logic is_io; // Access hits the I/O location.
	logic mem_we; // Write goes to the array.
	logic io_we; // Write goes to the output port.

	// Three-way address select.
	always_comb begin
		case (addr_sel)
			addr_pc: begin
				addr = pc; // Fetch.
			end
			addr_alu: begin
				addr = alu_out; // Load or store at computed address.
			end
			addr_a: begin
				addr = a_reg; // Access through A.
			end
			default: begin
				addr = pc; // Unused code falls back to fetch.
			end
		endcase
	end

	assign idx = addr[idx_w-1:0];
	assign is_io = (addr == io_addr);

	// Writes split between the array and the port.
	assign mem_we = mem_write & ~is_io;
	assign io_we = mem_write & is_io;

	// Array write port.
	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[idx] <= wdata; // Seen by reads from the next edge on.
		end
	end

	// Synchronous read, old data on a same-cycle write.
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (is_io) begin
			q <= io_in; // Sample the input port.
		end else begin
			q <= mem[idx];
		end
	end

	// Output port register.
	always_ff @(posedge clk) begin
		if (rst) begin
			io_out <= '0;
		end else if (io_we) begin
			io_out <= wdata; // Drives the port right after the edge.
		end
	end

	// MDR follows q every cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			mdr <= '0;
		end else begin
			mdr <= q; // One cycle behind the read.
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 20, // Clock period.
	parameter int reset_cycles = 4 // Rising edges with rst held high.
) (
	output logic clk, // Free-running clock.
	output logic rst // Sync reset, active high.
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk; // Half period per phase.
	end

	initial begin
		rst = 1'b1; // Held from time zero.
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0; // Released right after the last reset edge.
	end

endmodule

`default_nettype wire

// File: verif/tb_fetch_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_memory;

	import cpu_pkg::*;

	localparam int mem_words = 4096; // Depth passed to the DUT.
	localparam int clk_period = 20; // Matches the clock generator.
	// Per-test cycle budgets that the watchdog adds up.
	localparam int reset_cycles = 10;
	localparam int pc_cycles = 50;
	localparam int mem_cycles = 80;
	localparam int fetch_cycles = 30;
	localparam int io_cycles = 30;
	localparam int rand_cycles = 300;
	localparam int test_cycles = reset_cycles + pc_cycles + mem_cycles + fetch_cycles
		+ io_cycles + rand_cycles;

	logic clk;
	logic rst;
	logic pc_write;
	logic pc_is_branch;
	word_t new_pc;
	branch_type_e branch_type;
	logic zero;
	logic negative;
	addr_sel_e addr_sel;
	word_t alu_out;
	word_t a_reg;
	logic mem_write;
	word_t mem_wdata;
	word_t io_in;
	logic ir_write;
	word_t pc;
	word_t mdr;
	word_t io_out;
	ctrl_t ir_ctrl;
	reg_idx_t ir_rega;
	reg_idx_t ir_regb;
	reg_idx_t ir_regd;
	word_t ir_imm;

	word_t model_mem [mem_words]; // Mirror of every array write.
	word_t exp_pc; // Expected program counter.
	word_t exp_io; // Expected output port.
	integer seed = 32'hac39; // Seed for $random.
	int errors = 0; // Mismatches so far.
	int errors_at_start = 0; // Mismatches before the running test.
	int tests_run = 0;
	int tests_passed = 0;

	tb_clock_gen #(
		.period_ns    (clk_period),
		.reset_cycles (4)
	) clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	fetch_memory #(
		.mem_words (mem_words)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.pc_write     (pc_write),
		.pc_is_branch (pc_is_branch),
		.new_pc       (new_pc),
		.branch_type  (branch_type),
		.zero         (zero),
		.negative     (negative),
		.addr_sel     (addr_sel),
		.alu_out      (alu_out),
		.a_reg        (a_reg),
		.mem_write    (mem_write),
		.mem_wdata    (mem_wdata),
		.io_in        (io_in),
		.ir_write     (ir_write),
		.pc           (pc),
		.mdr          (mdr),
		.io_out       (io_out),
		.ir_ctrl      (ir_ctrl),
		.ir_rega      (ir_rega),
		.ir_regb      (ir_regb),
		.ir_regd      (ir_regd),
		.ir_imm       (ir_imm)
	);

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	// Array slot that an address aliases to.
	function automatic int model_index(input word_t addr);
		return int'(addr) % mem_words;
	endfunction

	function automatic logic branch_taken(input branch_type_e bt, input logic z, input logic n);
		logic taken;
		case (bt)
			br_eq: taken = (z == 1'b1);
			br_ne: taken = (z == 1'b0);
			br_lt: taken = (n == 1'b1);
			default: taken = (n == 1'b0); // br_ge.
		endcase
		return taken;
	endfunction

	// Six-bit two's complement value widened to a word.
	function automatic word_t expected_imm(input word_t instr);
		return instr[5] ? word_t'(instr[5:0]) - 16'd64 : word_t'(instr[5:0]);
	endfunction

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d mismatches", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	task automatic write_word(input word_t addr, input word_t data);
		@(posedge clk);
		addr_sel <= addr_alu; // Stores go through the ALU address.
		alu_out <= addr;
		mem_wdata <= data;
		mem_write <= 1'b1;
		@(posedge clk); // Write lands on this edge.
		mem_write <= 1'b0;
		if (addr == io_addr) begin
			exp_io = data;
		end else begin
			model_mem[model_index(addr)] = data;
		end
	endtask

	task automatic load_pc(input word_t value);
		@(posedge clk);
		pc_write <= 1'b1;
		pc_is_branch <= 1'b0; // Unconditional load.
		new_pc <= value;
		@(posedge clk);
		pc_write <= 1'b0;
		exp_pc = value;
	endtask

	// Read through one address source and compare mdr.
	task automatic read_check(input addr_sel_e sel, input word_t addr, input word_t exp);
		if (sel == addr_pc) begin
			load_pc(addr); // PC must hold the address first.
		end
		@(posedge clk);
		addr_sel <= sel;
		if (sel == addr_alu) begin
			alu_out <= addr;
		end else if (sel == addr_a) begin
			a_reg <= addr;
		end
		@(posedge clk); // Edge N samples the address.
		@(posedge clk); // Edge N+1 loads mdr.
		@(negedge clk);
		check_word("mdr", exp, mdr);
	endtask

	task automatic init_inputs();
		pc_write <= 1'b0;
		pc_is_branch <= 1'b0;
		new_pc <= '0;
		branch_type <= br_eq;
		zero <= 1'b0;
		negative <= 1'b0;
		addr_sel <= addr_pc;
		alu_out <= '0;
		a_reg <= '0;
		mem_write <= 1'b0;
		mem_wdata <= '0;
		io_in <= '0;
		ir_write <= 1'b0;
		exp_pc = '0;
		exp_io = '0;
	endtask

	task automatic reset_values();
		@(negedge clk);
		while (rst) @(negedge clk); // First low phase after the release.
		check_word("pc", 16'h0000, pc);
		check_word("mdr", 16'h0000, mdr);
		check_word("io_out", 16'h0000, io_out);
		check_ctrl("ir_ctrl", 7'h00, ir_ctrl);
		check_reg("ir_regd", 3'h0, ir_regd);
		check_reg("ir_rega", 3'h0, ir_rega);
		check_reg("ir_regb", 3'h0, ir_regb);
		check_word("ir_imm", 16'h0000, ir_imm);
	endtask

	task automatic pc_updates();
		word_t target;
		branch_type_e bt;
		logic z;
		logic n;
		load_pc(16'h0100);
		@(negedge clk);
		check_word("pc", exp_pc, pc);
		for (int b = 0; b < 4; b++) begin
			for (int f = 0; f < 4; f++) begin
				bt = branch_type_e'(b);
				z = (f % 2) == 1;
				n = f >= 2;
				target = 16'h2000 + word_t'(b * 16 + f); // Distinct per case.
				@(posedge clk);
				pc_write <= 1'b1;
				pc_is_branch <= 1'b1;
				new_pc <= target;
				branch_type <= bt;
				zero <= z;
				negative <= n;
				@(posedge clk);
				pc_write <= 1'b0;
				pc_is_branch <= 1'b0;
				if (branch_taken(bt, z, n)) begin
					exp_pc = target;
				end
				@(negedge clk);
				check_word("pc", exp_pc, pc);
			end
		end
		@(posedge clk);
		new_pc <= 16'hBEEF; // Ignored without a strobe.
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_word("pc", exp_pc, pc);
	endtask

	function automatic word_t mem_test_addr(input int i);
		case (i)
			0: return 16'h0000;
			1: return 16'h0001;
			2: return 16'h0123;
			3: return 16'h0800;
			4: return 16'h0FFE; // Near the top of the array.
			default: return 16'h7ABC; // Aliases into the array.
		endcase
	endfunction

	task automatic memory_rw();
		word_t addr;
		for (int i = 0; i < 6; i++) begin
			addr = mem_test_addr(i);
			write_word(addr, ~addr ^ word_t'(i * 16'h1357));
		end
		for (int i = 0; i < 6; i++) begin
			addr = mem_test_addr(i);
			read_check(addr_a, addr, model_mem[model_index(addr)]);
			read_check(addr_pc, addr, model_mem[model_index(addr)]);
		end
	endtask

	task automatic fetch_check(input word_t addr, input word_t instr);
		write_word(addr, instr);
		load_pc(addr);
		@(posedge clk);
		addr_sel <= addr_pc;
		@(posedge clk); // Edge N reads the word at pc.
		ir_write <= 1'b1;
		@(posedge clk); // Edge N+1 captures it.
		ir_write <= 1'b0;
		@(negedge clk);
		check_ctrl("ir_ctrl", ctrl_t'(instr >> 9), ir_ctrl);
		check_reg("ir_regd", reg_idx_t'((instr >> 6) & 16'h7), ir_regd);
		check_reg("ir_rega", reg_idx_t'((instr >> 3) & 16'h7), ir_rega);
		check_reg("ir_regb", reg_idx_t'(instr & 16'h7), ir_regb);
		check_word("ir_imm", expected_imm(instr), ir_imm);
	endtask

	task automatic instruction_fetch();
		fetch_check(16'h0040, 16'hA6D3); // Positive immediate.
		fetch_check(16'h0041, 16'h5E2B); // Negative immediate.
		fetch_check(16'h0042, 16'hFFE0); // Most negative immediate.
	endtask

	task automatic memory_mapped_io();
		word_t alias_addr;
		alias_addr = word_t'(mem_words - 1); // Same low bits as io_addr.
		write_word(alias_addr, 16'h3C3C);
		write_word(io_addr, 16'hC0DE);
		@(negedge clk);
		check_word("io_out", exp_io, io_out);
		read_check(addr_alu, alias_addr, model_mem[model_index(alias_addr)]);
		@(posedge clk);
		io_in <= 16'h9A5B;
		read_check(addr_a, io_addr, 16'h9A5B); // Port value through mdr.
		check_word("io_out", exp_io, io_out);
	endtask

	task automatic random_access();
		word_t addr;
		word_t data;
		word_t pick;
		int k;
		word_t written [$];
		for (int i = 0; i < 40; i++) begin
			addr = word_t'($random(seed));
			if (addr == io_addr) begin
				addr = 16'h0000; // Keep to the array.
			end
			data = word_t'($random(seed));
			write_word(addr, data);
			written.push_back(addr);
			k = $unsigned($random(seed)) % written.size();
			pick = written[k];
			case (i % 3)
				0: read_check(addr_alu, pick, model_mem[model_index(pick)]);
				1: read_check(addr_a, pick, model_mem[model_index(pick)]);
				default: read_check(addr_pc, pick, model_mem[model_index(pick)]);
			endcase
		end
	endtask

	initial begin
		init_inputs();
		reset_values();
		finish_test("reset");
		pc_updates();
		finish_test("pc_updates");
		memory_rw();
		finish_test("memory_rw");
		instruction_fetch();
		finish_test("instruction_fetch");
		memory_mapped_io();
		finish_test("memory_mapped_io");
		random_access();
		finish_test("random_access");
		$display("Summary: %0d tests, %0d passed, %0d failed", tests_run, tests_passed,
			tests_run - tests_passed);
		if (errors == 0 && tests_passed == tests_run) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Twice the summed test budget.
	initial begin
		#(test_cycles * 2 * clk_period);
		$display("Watchdog expired after %0d cycles, the run timed out", test_cycles * 2);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/cpu_pkg.sv
hdl/program_counter.sv
hdl/instruction_register.sv
hdl/unified_memory.sv
hdl/fetch_memory.sv
verif/tb_clock_gen.sv
verif/tb_fetch_memory.sv
